// File: tb.f
verilog/bus_pkg.sv
verilog/bus_arbiter.sv
verilog/mem_sram.sv
verilog/clint_timer.sv
verilog/serial_port.sv
verilog/resp_router.sv
verilog/soc_bus.sv
tb/clk_gen.sv
tb/tb_soc_bus.sv

// File: tb/tb_soc_bus.sv
`timescale 1ns/10ps

module tb_soc_bus
  import bus_pkg::*;
();

  localparam int SRAM_AW = 10;
  localparam int DEPTH = 1 << SRAM_AW;
  // bus operations issued by all tests together
  localparam int NUM_OPS = 24 + 12 + 4 + 3 + 3 + 216;
  // worst stall run plus overhead per operation
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40;
  // sram space only, 16 words of the prefill, upper bits alias
  localparam addr_t MIX_MASK = 32'h7fff_f03c;

  logic        clk;
  logic        reset_i;
  addr_t       ifu_araddr_i;
  logic        ifu_arvalid_i;
  logic        ifu_arready_o;
  data_t       ifu_rdata_o;
  logic        ifu_rvalid_o;
  addr_t       lsu_araddr_i;
  logic        lsu_arvalid_i;
  data_t       lsu_rdata_o;
  logic        lsu_rvalid_o;
  addr_t       lsu_awaddr_i;
  data_t       lsu_wdata_i;
  strb_t       lsu_wstrb_i;
  logic        lsu_wvalid_i;
  logic        lsu_wready_o;
  logic [7:0]  uart_tx_data_o;
  logic        uart_tx_valid_o;

  // reference copy of the sram
  data_t       ref_mem [DEPTH];
  logic [31:0] lcg_state = 32'h5959_ca23;
  int unsigned cycle_cnt = 0;
  int          errors = 0;
  int          checks = 0;
  int          uart_count = 0;
  logic        wr_uart_seen;
  logic [7:0]  wr_uart_byte;

  clk_gen u_clk_gen (
    .clk_o   (clk),
    .reset_o (reset_i)
  );

  soc_bus #(
    .SRAM_AW  (SRAM_AW),
    .STALL_EN (1)
  ) DUT (
    .clk             (clk),
    .reset_i         (reset_i),
    .ifu_araddr_i    (ifu_araddr_i),
    .ifu_arvalid_i   (ifu_arvalid_i),
    .ifu_arready_o   (ifu_arready_o),
    .ifu_rdata_o     (ifu_rdata_o),
    .ifu_rvalid_o    (ifu_rvalid_o),
    .lsu_araddr_i    (lsu_araddr_i),
    .lsu_arvalid_i   (lsu_arvalid_i),
    .lsu_rdata_o     (lsu_rdata_o),
    .lsu_rvalid_o    (lsu_rvalid_o),
    .lsu_awaddr_i    (lsu_awaddr_i),
    .lsu_wdata_i     (lsu_wdata_i),
    .lsu_wstrb_i     (lsu_wstrb_i),
    .lsu_wvalid_i    (lsu_wvalid_i),
    .lsu_wready_o    (lsu_wready_o),
    .uart_tx_data_o  (uart_tx_data_o),
    .uart_tx_valid_o (uart_tx_valid_o)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // every serial byte that leaves the top level
  always @(negedge clk) begin
    if (uart_tx_valid_o) begin
      uart_count <= uart_count + 1;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // sram words wrap every DEPTH words
  function automatic int unsigned word_index(addr_t addr);
    return (addr >> 2) % DEPTH;
  endfunction

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic check_word(input string name, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    checks++;
    assert (ok === 1'b1) else begin
      errors++;
      $display("ERROR: %s", what);
    end
  endtask

  task automatic do_store(input addr_t addr, input data_t data, input strb_t strb);
    @(negedge clk);
    lsu_awaddr_i = addr;
    lsu_wdata_i  = data;
    lsu_wstrb_i  = strb;
    lsu_wvalid_i = 1'b1;
    do begin
      @(negedge clk);
    end while (!lsu_wready_o);
    wr_uart_seen = uart_tx_valid_o;
    wr_uart_byte = uart_tx_data_o;
    lsu_wvalid_i = 1'b0;
    // the serial address leaves sram alone on writes
    if (addr != SERIAL_PORT_ADDR) begin
      ref_mem[word_index(addr)] = merge_bytes(ref_mem[word_index(addr)], data, strb);
    end
  endtask

  task automatic do_load(input addr_t addr, output data_t rdata, output int unsigned done_cycle);
    @(negedge clk);
    lsu_araddr_i  = addr;
    lsu_arvalid_i = 1'b1;
    do begin
      @(negedge clk);
    end while (!lsu_rvalid_o);
    rdata = lsu_rdata_o;
    done_cycle = cycle_cnt;
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic load_check(input addr_t addr);
    data_t       got;
    int unsigned t;
    do_load(addr, got, t);
    check_word("lsu_rdata_o", got, ref_mem[word_index(addr)]);
  endtask

  task automatic fetch_check(input addr_t addr);
    int grants;
    grants = 0;
    @(negedge clk);
    ifu_araddr_i  = addr;
    ifu_arvalid_i = 1'b1;
    do begin
      @(negedge clk);
      if (ifu_arready_o) begin
        grants++;
      end
    end while (!ifu_rvalid_o);
    check_word("ifu_rdata_o", ifu_rdata_o, ref_mem[word_index(addr)]);
    ifu_arvalid_i = 1'b0;
    check_true(grants == 1, "fetch was not granted exactly once before its read data");
  endtask

  task automatic test_store_load();
    addr_t addr;
    for (int i = 0; i < 8; i++) begin
      addr = next_rand() & 32'h7fff_fffc;
      do_store(addr, next_rand(), 4'hf);
      load_check(addr);
      fetch_check(addr);
    end
  endtask

  task automatic test_byte_strobes();
    addr_t addr;
    strb_t strbs [5];
    addr = 32'h0000_0100;
    strbs = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011};
    do_store(addr, 32'h1122_3344, 4'hf);
    load_check(addr);
    foreach (strbs[i]) begin
      do_store(addr, next_rand(), strbs[i]);
      load_check(addr);
    end
  endtask

  task automatic test_priority();
    addr_t addr_a;
    addr_t addr_b;
    data_t data_a;
    data_t data_b;
    logic  lsu_seen;
    logic  ifu_seen;
    addr_a = 32'h0000_0200;
    addr_b = 32'h0000_0204;
    data_a = next_rand();
    data_b = next_rand();
    do_store(addr_a, data_a, 4'hf);
    do_store(addr_b, data_b, 4'hf);
    lsu_seen = 1'b0;
    ifu_seen = 1'b0;
    // both clients ask in the same cycle
    @(negedge clk);
    ifu_araddr_i  = addr_a;
    ifu_arvalid_i = 1'b1;
    lsu_araddr_i  = addr_b;
    lsu_arvalid_i = 1'b1;
    while (!(lsu_seen && ifu_seen)) begin
      @(negedge clk);
      if (lsu_wready_o) begin
        check_true(1'b0, "store completion pulsed while only reads were pending");
      end
      if (lsu_rvalid_o) begin
        check_true(!lsu_seen && !ifu_seen, "load completion came late or twice");
        check_word("lsu_rdata_o", lsu_rdata_o, data_b);
        lsu_arvalid_i = 1'b0;
        lsu_seen = 1'b1;
      end
      if (ifu_rvalid_o) begin
        check_true(lsu_seen && !lsu_rvalid_o && !ifu_seen,
                   "fetch completed before or together with the load, or twice");
        check_word("ifu_rdata_o", ifu_rdata_o, data_a);
        ifu_arvalid_i = 1'b0;
        ifu_seen = 1'b1;
      end
    end
  endtask

  task automatic test_timer();
    data_t       hi;
    data_t       lo_a;
    data_t       lo_b;
    int unsigned t_hi;
    int unsigned t_a;
    int unsigned t_b;
    do_load(CLINT_MTIME_HI, hi, t_hi);
    check_word("lsu_rdata_o", hi, 32'h0);
    do_load(CLINT_MTIME_LO, lo_a, t_a);
    do_load(CLINT_MTIME_LO, lo_b, t_b);
    // both samples see the same fixed latency
    check_word("lsu_rdata_o delta", lo_b - lo_a, t_b - t_a);
  endtask

  task automatic test_serial();
    addr_t alias_addr;
    data_t data;
    alias_addr = SERIAL_PORT_ADDR & 32'h0000_0ffc;
    do_store(alias_addr, next_rand(), 4'hf);
    data = next_rand();
    do_store(SERIAL_PORT_ADDR, data, 4'hf);
    check_true(wr_uart_seen, "serial strobe missing in the store completion cycle");
    check_word("uart_tx_data_o", wr_uart_byte, data[7:0]);
    repeat (3) @(negedge clk);
    check_true(uart_count == 1, "serial port did not send exactly one byte");
    load_check(SERIAL_PORT_ADDR);
  endtask

  task automatic test_random_mix();
    addr_t       addr;
    logic [31:0] rnd;
    for (int i = 0; i < 16; i++) begin
      do_store(i * 4, next_rand(), 4'hf);
    end
    for (int n = 0; n < 200; n++) begin
      rnd  = next_rand();
      addr = next_rand() & MIX_MASK;
      if (rnd[31]) begin
        do_store(addr, next_rand(), rnd[27:24]);
      end else begin
        load_check(addr);
      end
    end
  endtask

  initial begin
    ifu_araddr_i  = '0;
    ifu_arvalid_i = 1'b0;
    lsu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_awaddr_i  = '0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    lsu_wvalid_i  = 1'b0;
    wait (reset_i === 1'b0);
    test_store_load();
    test_byte_strobes();
    test_priority();
    test_timer();
    test_serial();
    test_random_mix();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("ERROR: timeout after %0d cycles, a completion pulse never arrived", cycle_cnt);
    $display("checks run: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/10ps

module clk_gen (
  output logic clk_o,
  output logic reset_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset covers the first two rising edges
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

// File: verilog/soc_bus.sv
`timescale 1ns/10ps

module soc_bus
  import bus_pkg::*;
#(
  parameter int SRAM_AW  = 10,
  parameter int STALL_EN = 1
) (
  input  logic       clk,
  input  logic       reset_i,
  input  addr_t      ifu_araddr_i,
  input  logic       ifu_arvalid_i,
  output logic       ifu_arready_o,
  output data_t      ifu_rdata_o,
  output logic       ifu_rvalid_o,
  input  addr_t      lsu_araddr_i,
  input  logic       lsu_arvalid_i,
  output data_t      lsu_rdata_o,
  output logic       lsu_rvalid_o,
  input  addr_t      lsu_awaddr_i,
  input  data_t      lsu_wdata_i,
  input  strb_t      lsu_wstrb_i,
  input  logic       lsu_wvalid_i,
  output logic       lsu_wready_o,
  output logic [7:0] uart_tx_data_o,
  output logic       uart_tx_valid_o
);

  arb_state_t arb_state;
  addr_t      req_addr;
  data_t      req_wdata;
  strb_t      req_wstrb;
  logic       req_write;
  logic       sram_start;
  logic       clint_start;
  logic       uart_start;
  logic       sram_done;
  logic       clint_done;
  logic       uart_done;
  data_t      sram_rdata;
  data_t      clint_rdata;
  logic       txn_done;

  bus_arbiter u_arbiter (
    .clk           (clk),
    .reset_i       (reset_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wvalid_i  (lsu_wvalid_i),
    .txn_done_i    (txn_done),
    .arb_state_o   (arb_state),
    .ifu_arready_o (ifu_arready_o),
    .req_addr_o    (req_addr),
    .req_wdata_o   (req_wdata),
    .req_wstrb_o   (req_wstrb),
    .req_write_o   (req_write),
    .sram_start_o  (sram_start),
    .clint_start_o (clint_start),
    .uart_start_o  (uart_start)
  );

  mem_sram #(
    .SRAM_AW  (SRAM_AW),
    .STALL_EN (STALL_EN)
  ) u_sram (
    .clk     (clk),
    .reset_i (reset_i),
    .start_i (sram_start),
    .addr_i  (req_addr),
    .wdata_i (req_wdata),
    .wstrb_i (req_wstrb),
    .write_i (req_write),
    .done_o  (sram_done),
    .rdata_o (sram_rdata)
  );

  clint_timer u_clint (
    .clk     (clk),
    .reset_i (reset_i),
    .start_i (clint_start),
    .addr_i  (req_addr),
    .done_o  (clint_done),
    .rdata_o (clint_rdata)
  );

  serial_port u_uart (
    .clk        (clk),
    .reset_i    (reset_i),
    .start_i    (uart_start),
    .wdata_i    (req_wdata),
    .done_o     (uart_done),
    .tx_data_o  (uart_tx_data_o),
    .tx_valid_o (uart_tx_valid_o)
  );

  resp_router u_router (
    .arb_state_i   (arb_state),
    .sram_done_i   (sram_done),
    .sram_rdata_i  (sram_rdata),
    .clint_done_i  (clint_done),
    .clint_rdata_i (clint_rdata),
    .uart_done_i   (uart_done),
    .txn_done_o    (txn_done),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .ifu_rdata_o   (ifu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_wready_o  (lsu_wready_o)
  );

endmodule

// File: verilog/resp_router.sv
`timescale 1ns/10ps

module resp_router
  import bus_pkg::*;
(
  input  arb_state_t arb_state_i,
  input  logic       sram_done_i,
  input  data_t      sram_rdata_i,
  input  logic       clint_done_i,
  input  data_t      clint_rdata_i,
  input  logic       uart_done_i,
  output logic       txn_done_o,
  output logic       ifu_rvalid_o,
  output data_t      ifu_rdata_o,
  output logic       lsu_rvalid_o,
  output data_t      lsu_rdata_o,
  output logic       lsu_wready_o
);

  data_t rdata;

  // only one device is active at a time
  assign txn_done_o = sram_done_i | clint_done_i | uart_done_i;

  always_comb begin
    rdata = '0;
    if (sram_done_i) begin
      rdata = sram_rdata_i;
    end else if (clint_done_i) begin
      rdata = clint_rdata_i;
    end
  end

  // steer by owner
  assign ifu_rvalid_o = txn_done_o && (arb_state_i == ARB_IFU_RD);
  assign lsu_rvalid_o = txn_done_o && (arb_state_i == ARB_LSU_RD);
  assign lsu_wready_o = txn_done_o && (arb_state_i == ARB_LSU_WR);

  assign ifu_rdata_o = ifu_rvalid_o ? rdata : '0;
  assign lsu_rdata_o = lsu_rvalid_o ? rdata : '0;

endmodule

// File: verilog/serial_port.sv
`timescale 1ns/10ps

module serial_port
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  logic       start_i,
  input  data_t      wdata_i,
  output logic       done_o,
  output logic [7:0] tx_data_o,
  output logic       tx_valid_o
);

  logic [7:0] tx_byte_q;
  logic       sent_q;

  // byte out goes with the bus completion
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sent_q <= 1'b0;
    end else begin
      sent_q <= start_i;
    end
  end

  // low byte only, held until the next write
  always_ff @(posedge clk) begin
    if (start_i) begin
      tx_byte_q <= wdata_i[7:0];
    end
  end

  assign tx_data_o  = tx_byte_q;
  assign tx_valid_o = sent_q;
  assign done_o     = sent_q;

endmodule

// File: verilog/clint_timer.sv
`timescale 1ns/10ps

module clint_timer
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  reset_i,
  input  logic  start_i,
  input  addr_t addr_i,
  output logic  done_o,
  output data_t rdata_o
);

  logic [63:0] mtime_q;
  logic        done_q;
  data_t       rdata_q;

  // free running, no compare
  always_ff @(posedge clk) begin
    if (reset_i) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= start_i;
    end
  end

  // sample the requested half at the strobe
  always_ff @(posedge clk) begin
    if (start_i) begin
      if (addr_i == CLINT_MTIME_HI) begin
        rdata_q <= mtime_q[63:32];
      end else begin
        rdata_q <= mtime_q[31:0];
      end
    end
  end

  assign done_o  = done_q;
  assign rdata_o = rdata_q;

endmodule

// File: verilog/mem_sram.sv
`timescale 1ns/10ps

module mem_sram
  import bus_pkg::*;
#(
  parameter int SRAM_AW  = 10,
  parameter int STALL_EN = 1
) (
  input  logic  clk,
  input  logic  reset_i,
  input  logic  start_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  strb_t wstrb_i,
  input  logic  write_i,
  output logic  done_o,
  output data_t rdata_o
);

  localparam int DEPTH = 1 << SRAM_AW;

  data_t              mem [DEPTH];
  logic [19:0]        lfsr_q;
  logic               pend_q;
  logic               done_q;
  data_t              rdata_q;
  logic [SRAM_AW-1:0] idx;
  logic               active;
  logic               go;

  // word index, upper address bits alias
  assign idx = addr_i[SRAM_AW+1:2];

  // stall source, never reaches all zeros from a nonzero seed
  always_ff @(posedge clk) begin
    if (reset_i) begin
      lfsr_q <= 20'd1;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[18]};
    end
  end

  assign active = start_i | pend_q;
  assign go     = active && ((STALL_EN == 0) || lfsr_q[19]);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pend_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      pend_q <= active && !go;
      done_q <= go;
    end
  end

  // addr and data stay stable in the arbiter while pending
  always_ff @(posedge clk) begin
    if (go) begin
      if (write_i) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
          if (wstrb_i[b]) begin
            mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  assign done_o  = done_q;
  assign rdata_o = rdata_q;

endmodule

// File: verilog/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  addr_t      ifu_araddr_i,
  input  logic       ifu_arvalid_i,
  input  addr_t      lsu_araddr_i,
  input  logic       lsu_arvalid_i,
  input  addr_t      lsu_awaddr_i,
  input  data_t      lsu_wdata_i,
  input  strb_t      lsu_wstrb_i,
  input  logic       lsu_wvalid_i,
  input  logic       txn_done_i,
  output arb_state_t arb_state_o,
  output logic       ifu_arready_o,
  output addr_t      req_addr_o,
  output data_t      req_wdata_o,
  output strb_t      req_wstrb_o,
  output logic       req_write_o,
  output logic       sram_start_o,
  output logic       clint_start_o,
  output logic       uart_start_o
);

  arb_state_t state_q;
  arb_state_t pick;
  logic       first_q;
  addr_t      addr_q;
  data_t      wdata_q;
  strb_t      wstrb_q;
  dev_sel_t   dev_sel;

  // store beats load beats fetch
  always_comb begin
    pick = ARB_IDLE;
    if (lsu_wvalid_i) begin
      pick = ARB_LSU_WR;
    end else if (lsu_arvalid_i) begin
      pick = ARB_LSU_RD;
    end else if (ifu_arvalid_i) begin
      pick = ARB_IFU_RD;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= ARB_IDLE;
      first_q <= 1'b0;
    end else begin
      first_q <= 1'b0;
      if (state_q == ARB_IDLE) begin
        state_q <= pick;
        first_q <= (pick != ARB_IDLE);
      end else if (txn_done_i) begin
        state_q <= ARB_IDLE;
      end
    end
  end

  // winner's address and data, held for the whole transaction
  always_ff @(posedge clk) begin
    if (state_q == ARB_IDLE) begin
      case (pick)
        ARB_LSU_WR: begin
          addr_q  <= lsu_awaddr_i;
          wdata_q <= lsu_wdata_i;
          wstrb_q <= lsu_wstrb_i;
        end
        ARB_LSU_RD: begin
          addr_q  <= lsu_araddr_i;
          wstrb_q <= '0;
        end
        ARB_IFU_RD: begin
          addr_q  <= ifu_araddr_i;
          wstrb_q <= '0;
        end
        default: ;
      endcase
    end
  end

  assign req_write_o = (state_q == ARB_LSU_WR);

  // serial port takes writes only, timer reads only; the rest lands in sram
  always_comb begin
    dev_sel = DEV_SRAM;
    if (req_write_o && addr_q == SERIAL_PORT_ADDR) begin
      dev_sel = DEV_UART;
    end else if (!req_write_o && (addr_q == CLINT_MTIME_LO || addr_q == CLINT_MTIME_HI)) begin
      dev_sel = DEV_CLINT;
    end
  end

  // one strobe in the first busy cycle
  assign sram_start_o  = first_q && (dev_sel == DEV_SRAM);
  assign clint_start_o = first_q && (dev_sel == DEV_CLINT);
  assign uart_start_o  = first_q && (dev_sel == DEV_UART);
  assign ifu_arready_o = first_q && (state_q == ARB_IFU_RD);

  assign arb_state_o = state_q;
  assign req_addr_o  = addr_q;
  assign req_wdata_o = wdata_q;
  assign req_wstrb_o = wstrb_q;

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BYTES_PER_WORD = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BYTES_PER_WORD-1:0] strb_t;

  // memory map of the fixed devices
  localparam addr_t CLINT_MTIME_LO = 32'ha000_0048;
  localparam addr_t CLINT_MTIME_HI = 32'ha000_004c;
  localparam addr_t SERIAL_PORT_ADDR = 32'ha000_03f8;

  // decoded target of the current transaction
  typedef enum logic [1:0] {
    DEV_SRAM,
    DEV_CLINT,
    DEV_UART
  } dev_sel_t;

  // arbiter state, also tells who owns the bus
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_IFU_RD,
    ARB_LSU_RD,
    ARB_LSU_WR
  } arb_state_t;

endpackage
